// File: Makefile
# Verilator build and run of the load unit testbench

VERILATOR ?= verilator
TOP       ?= loadUnitTb
FILELIST  ?= all.f
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# the simulator exits with a failing status on any error
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
design/lsuPkg.sv
design/loadIssue.sv
design/loadLane.sv
design/missArbiter.sv
design/loadUnit.sv
testbench/loadUnitTb.sv

// File: design/loadIssue.sv
// load issue stage, spreads requesters over the lanes in rotating order and sends cache-table reads
`timescale 1ns/10ps
`default_nettype none

module loadIssue (
    input  logic              clk,
    input  logic              rst,

    // one request per address generator
    input  logic              reqValid[lsuPkg::numLanes],
    input  lsuPkg::addr_t     reqAddr[lsuPkg::numLanes],
    input  lsuPkg::loadId_t   reqId[lsuPkg::numLanes],

    // cache busy level per lane, sampled when the load issues
    input  logic              cacheBusy[lsuPkg::numLanes],

    // load handed to each lane
    output logic              laneValid[lsuPkg::numLanes],
    output lsuPkg::addr_t     laneAddr[lsuPkg::numLanes],
    output lsuPkg::loadId_t   laneId[lsuPkg::numLanes],
    output logic              issueBusy[lsuPkg::numLanes],

    // cache-table read per lane
    output logic              ctRe[lsuPkg::numLanes],
    output lsuPkg::index_t    ctIdx[lsuPkg::numLanes]
);

    import lsuPkg::*;

    // requester that the first lane serves this cycle
    lane_t startIdx;

    // requester served by each lane
    lane_t laneReq[numLanes];

    // rotate by one every cycle so both lanes see the same pressure
    always_ff @(posedge clk) begin
        if (rst) begin
            startIdx <= '0;
        end else if (startIdx == lane_t'(numLanes - 1)) begin
            startIdx <= '0;
        end else begin
            startIdx <= startIdx + 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < numLanes; i++) begin
            laneReq[i] = lane_t'((int'(startIdx) + i) % numLanes);
        end
    end

    // the read goes out in the same cycle the request is taken
    always_comb begin
        for (int i = 0; i < numLanes; i++) begin
            laneValid[i] = reqValid[laneReq[i]];
            laneAddr[i]  = reqAddr[laneReq[i]];
            laneId[i]    = reqId[laneReq[i]];
            ctRe[i]      = reqValid[laneReq[i]];
            ctIdx[i]     = reqAddr[laneReq[i]][idxLen-1:0];
            // a busy cache does not stall, the lane reports a conflict later
            issueBusy[i] = reqValid[laneReq[i]] && cacheBusy[i];
        end
    end

endmodule

`default_nettype wire

// File: design/loadLane.sv
// one load lane, a two-stage delay line that checks the cache-table result and forms hits or misses
`timescale 1ns/10ps
`default_nettype none

module loadLane (
    input  logic              clk,
    input  logic              rst,

    // load from the issue stage
    input  logic              inValid,
    input  lsuPkg::addr_t     inAddr,
    input  lsuPkg::loadId_t   inId,
    input  logic              inBusy,

    // cache-table result, arrives while the load sits in stage one
    input  logic              ctTagValid[lsuPkg::numWays],
    input  lsuPkg::tag_t      ctTag[lsuPkg::numWays],
    input  lsuPkg::way_t      victimWay,
    input  lsuPkg::data_t     ctData[lsuPkg::numWays],

    // outcome of the load
    output logic              outValid,
    output lsuPkg::loadId_t   outId,
    output lsuPkg::addr_t     outAddr,
    output logic              outHit,
    output lsuPkg::data_t     outData,
    output logic              outMiss,
    output lsuPkg::missType_e outMissType,
    output lsuPkg::addr_t     outWriteAddr,
    output lsuPkg::way_t      outWay
);

    import lsuPkg::*;

    // stage zero, waiting for the table read
    logic    s0Valid;
    addr_t   s0Addr;
    loadId_t s0Id;
    logic    s0Busy;

    // stage one, table result is present
    logic    s1Valid;
    addr_t   s1Addr;
    loadId_t s1Id;
    logic    s1Busy;

    // tag compare
    tag_t                 loadTag;
    logic [numWays-1:0]   hitVec;
    logic                 anyHit;
    way_t                 hitWay;

    always_ff @(posedge clk) begin
        if (rst) begin
            s0Valid <= 1'b0;
            s1Valid <= 1'b0;
        end else begin
            s0Valid <= inValid;
            s1Valid <= s0Valid;
        end
    end

    // payload moves along with the valids
    always_ff @(posedge clk) begin
        s0Addr <= inAddr;
        s0Id   <= inId;
        s0Busy <= inBusy;
        s1Addr <= s0Addr;
        s1Id   <= s0Id;
        s1Busy <= s0Busy;
    end

    assign loadTag = s1Addr[addrWidth-1:idxLen];

    always_comb begin
        anyHit = 1'b0;
        hitWay = '0;
        for (int w = 0; w < numWays; w++) begin
            hitVec[w] = ctTagValid[w] && (ctTag[w] == loadTag);
            if (hitVec[w]) begin
                anyHit = 1'b1;
                hitWay = way_t'(w);
            end
        end
    end

    // busy at issue wins over a hit, the load must be reissued
    always_comb begin
        outHit  = s1Valid && !s1Busy && anyHit;
        outMiss = s1Valid && (s1Busy || !anyHit);
        if (s1Busy) begin
            outMissType = missConflict;
        end else if (!ctTagValid[victimWay]) begin
            outMissType = missNoEvict;
        end else begin
            outMissType = missRegular;
        end
    end

    assign outValid     = s1Valid;
    assign outId        = s1Id;
    assign outAddr      = s1Addr;
    assign outData      = ctData[hitWay];
    // line that the refill evicts
    assign outWriteAddr = {ctTag[victimWay], s1Addr[idxLen-1:0]};
    assign outWay       = anyHit ? hitWay : victimWay;

    // the table never holds the same line in two ways
    assert property (@(posedge clk) disable iff (rst)
        s1Valid |-> $onehot0(hitVec));

endmodule

`default_nettype wire

// File: design/loadUnit.sv
// top level of the load unit, connects issue stage, load lanes and miss arbiter
`timescale 1ns/10ps
`default_nettype none

module loadUnit (
    input  logic              clk,
    input  logic              rst,

    // requests from the address generators
    input  logic              reqValid[lsuPkg::numLanes],
    input  lsuPkg::addr_t     reqAddr[lsuPkg::numLanes],
    input  lsuPkg::loadId_t   reqId[lsuPkg::numLanes],

    // cache table
    output logic              ctRe[lsuPkg::numLanes],
    output lsuPkg::index_t    ctIdx[lsuPkg::numLanes],
    input  logic              ctTagValid[lsuPkg::numLanes][lsuPkg::numWays],
    input  lsuPkg::tag_t      ctTag[lsuPkg::numLanes][lsuPkg::numWays],
    input  lsuPkg::way_t      victimWay[lsuPkg::numLanes],
    input  lsuPkg::data_t     ctData[lsuPkg::numLanes][lsuPkg::numWays],
    input  logic              cacheBusy[lsuPkg::numLanes],

    // refill side
    output logic              missValid,
    output lsuPkg::missType_e missType,
    output lsuPkg::addr_t     missAddr,
    output lsuPkg::addr_t     missWriteAddr,
    output lsuPkg::way_t      missWay,
    input  logic              missReady,

    // results and acknowledges
    output logic              resValid[lsuPkg::numLanes],
    output lsuPkg::loadId_t   resId[lsuPkg::numLanes],
    output lsuPkg::data_t     resData[lsuPkg::numLanes],
    output logic              ackFail[lsuPkg::numLanes],
    output lsuPkg::loadId_t   ackId[lsuPkg::numLanes],
    output lsuPkg::addr_t     ackAddr[lsuPkg::numLanes]
);

    import lsuPkg::*;

    // issue stage to lanes
    logic      issueValid[numLanes];
    addr_t     issueAddr[numLanes];
    loadId_t   issueId[numLanes];
    logic      issueBusy[numLanes];

    // lanes to arbiter
    logic      laneValid[numLanes];
    loadId_t   laneId[numLanes];
    addr_t     laneAddr[numLanes];
    logic      laneHit[numLanes];
    data_t     laneData[numLanes];
    logic      laneMiss[numLanes];
    missType_e laneMissType[numLanes];
    addr_t     laneWriteAddr[numLanes];
    way_t      laneWay[numLanes];

    loadIssue issue (
        .clk(clk), .rst(rst),
        .reqValid(reqValid), .reqAddr(reqAddr), .reqId(reqId), .cacheBusy(cacheBusy),
        .laneValid(issueValid), .laneAddr(issueAddr), .laneId(issueId),
        .issueBusy(issueBusy), .ctRe(ctRe), .ctIdx(ctIdx)
    );

    for (genvar i = 0; i < numLanes; i++) begin : genLane
        loadLane lane (
            .clk(clk), .rst(rst),
            .inValid(issueValid[i]), .inAddr(issueAddr[i]), .inId(issueId[i]),
            .inBusy(issueBusy[i]),
            .ctTagValid(ctTagValid[i]), .ctTag(ctTag[i]), .victimWay(victimWay[i]),
            .ctData(ctData[i]),
            .outValid(laneValid[i]), .outId(laneId[i]), .outAddr(laneAddr[i]),
            .outHit(laneHit[i]), .outData(laneData[i]), .outMiss(laneMiss[i]),
            .outMissType(laneMissType[i]), .outWriteAddr(laneWriteAddr[i]),
            .outWay(laneWay[i])
        );
    end

    missArbiter arbiter (
        .laneValid(laneValid), .laneId(laneId), .laneAddr(laneAddr), .laneHit(laneHit),
        .laneData(laneData), .laneMiss(laneMiss), .laneMissType(laneMissType),
        .laneWriteAddr(laneWriteAddr), .laneWay(laneWay),
        .missReady(missReady), .missValid(missValid), .missType(missType),
        .missAddr(missAddr), .missWriteAddr(missWriteAddr), .missWay(missWay),
        .resValid(resValid), .resId(resId), .resData(resData),
        .ackFail(ackFail), .ackId(ackId), .ackAddr(ackAddr)
    );

endmodule

`default_nettype wire

// File: design/lsuPkg.sv
// shared widths, constants and types of the load unit, imported by every RTL module and the testbench
`default_nettype none

package lsuPkg;

    // load lanes, one per address generator
    localparam int numLanes = 2;

    // cache associativity
    localparam int numWays = 4;

    // byte address width
    localparam int addrWidth = 32;

    // low address bits that index the cache table
    localparam int idxLen = 12;

    // log2 of the line size in bytes
    localparam int lineSizeE = 4;

    // load identifier width
    localparam int idWidth = 6;

    // full byte address
    typedef logic [addrWidth-1:0] addr_t;

    // line tag, the address bits above the table index
    typedef logic [addrWidth-idxLen-1:0] tag_t;

    // cache-table index
    typedef logic [idxLen-1:0] index_t;

    // way number within a set
    typedef logic [$clog2(numWays)-1:0] way_t;

    // lane number, also used for requester numbers
    typedef logic [$clog2(numLanes)-1:0] lane_t;

    // load identifier returned with results and acknowledges
    typedef logic [idWidth-1:0] loadId_t;

    // one loaded data word
    typedef logic [31:0] data_t;

    // kind of miss sent to the refill side
    // conflict misses are never forwarded, the load is reissued instead
    typedef enum logic [1:0] {
        missRegular,
        missNoEvict,
        missConflict
    } missType_e;

endpackage

`default_nettype wire

// File: design/missArbiter.sv
// miss arbiter, forwards one miss to the refill side and turns lane outcomes into results and acks
`timescale 1ns/10ps
`default_nettype none

module missArbiter (
    // lane outcomes
    input  logic              laneValid[lsuPkg::numLanes],
    input  lsuPkg::loadId_t   laneId[lsuPkg::numLanes],
    input  lsuPkg::addr_t     laneAddr[lsuPkg::numLanes],
    input  logic              laneHit[lsuPkg::numLanes],
    input  lsuPkg::data_t     laneData[lsuPkg::numLanes],
    input  logic              laneMiss[lsuPkg::numLanes],
    input  lsuPkg::missType_e laneMissType[lsuPkg::numLanes],
    input  lsuPkg::addr_t     laneWriteAddr[lsuPkg::numLanes],
    input  lsuPkg::way_t      laneWay[lsuPkg::numLanes],

    // refill side
    input  logic              missReady,
    output logic              missValid,
    output lsuPkg::missType_e missType,
    output lsuPkg::addr_t     missAddr,
    output lsuPkg::addr_t     missWriteAddr,
    output lsuPkg::way_t      missWay,

    // per-lane results and acknowledges
    output logic              resValid[lsuPkg::numLanes],
    output lsuPkg::loadId_t   resId[lsuPkg::numLanes],
    output lsuPkg::data_t     resData[lsuPkg::numLanes],
    output logic              ackFail[lsuPkg::numLanes],
    output lsuPkg::loadId_t   ackId[lsuPkg::numLanes],
    output lsuPkg::addr_t     ackAddr[lsuPkg::numLanes]
);

    import lsuPkg::*;

    // lane whose miss drives the miss output
    logic [numLanes-1:0] forward;

    always_comb begin
        missValid     = 1'b0;
        missType      = missRegular;
        missAddr      = '0;
        missWriteAddr = '0;
        missWay       = '0;

        // lowest lane with a forwardable miss wins
        for (int i = 0; i < numLanes; i++) begin
            forward[i] = 1'b0;
            if (!missValid && laneValid[i] && laneMiss[i] && laneMissType[i] != missConflict) begin
                forward[i]    = 1'b1;
                missValid     = 1'b1;
                missType      = laneMissType[i];
                missAddr      = laneAddr[i];
                missWriteAddr = laneWriteAddr[i];
                missWay       = laneWay[i];
            end
        end

        for (int i = 0; i < numLanes; i++) begin
            resValid[i] = laneValid[i] && laneHit[i];
            resId[i]    = laneId[i];
            resData[i]  = laneData[i];
            // an accepted miss waits for the refill, anything else is reissued
            ackFail[i]  = laneValid[i] && laneMiss[i] && !(forward[i] && missReady);
            ackId[i]    = laneId[i];
            ackAddr[i]  = laneAddr[i];
            assert (!(resValid[i] && ackFail[i]));
        end
    end

endmodule

`default_nettype wire

// File: testbench/loadInput.txt
# preload: W set way valid tag data, V set victimWay (hex)
# cycle: C busy0 busy1 missReady, per requester: kind addr id expected (data or write address)
# kind 0 idle, 1 hit, 2 regular miss, 3 no-evict miss, 4 conflict
V 010 3
W 010 0 1 12345 11110000
W 010 1 1 23456 22221111
W 010 2 1 0ab00 33332222
V 020 1
W 020 0 1 31000 a0a00000
W 020 1 1 31001 a1a10001
W 020 2 1 31002 a2a20002
W 020 3 1 31003 a3a30003
V 030 2
W 030 0 1 40000 b0b00030
W 030 1 1 40001 b1b10031
W 030 2 1 40002 b2b20032
V 040 0
V 050 2
W 050 0 1 50000 c0c00050
W 050 1 1 50001 c1c10051
W 050 2 1 50002 c2c20052
W 050 3 1 50003 c3c30053
C 0 0 1  1 12345010 01 11110000  1 23456010 02 22221111
C 0 0 1  1 31002020 03 a2a20002  1 40001030 04 b1b10031
C 0 0 1  3 55555010 05 0         1 0ab00010 06 33332222
C 0 0 1  0 0 0 0                 2 77777020 07 31001020
C 0 0 1  3 66666040 08 0         2 88888050 09 50002050
C 0 0 0  2 99999020 0a 31001020  0 0 0 0
C 1 1 1  4 12345010 0b 0         4 abcde040 0c 0
C 0 0 0  1 40002030 0d b2b20032  2 12121030 0e 40002030
C 0 0 1  0 0 0 0                 0 0 0 0
C 1 1 1  4 31000020 0f 0         0 0 0 0
C 0 0 1  1 50003050 10 c3c30053  1 50000050 11 c0c00050
C 0 0 1  2 abcab050 12 50002050  3 fedcb040 13 0
C 0 0 0  3 13579040 14 0         3 24680010 15 0
C 0 0 1  1 31003020 16 a3a30003  0 0 0 0

// File: testbench/loadUnitTb.sv
// testbench of the load unit, replays the cycle lines of the input file against a cache-table model
`timescale 1ns/10ps
`default_nettype none

module loadUnitTb;

    import lsuPkg::*;

    localparam int clkPeriod = 4;
    localparam int resetCycles = 16;
    localparam int timeoutMargin = 200;
    localparam logic [31:0] randSeed = 32'h8e00e0ac;
    localparam string inputFile = "testbench/loadInput.txt";
    localparam int maxCycles = 256;
    localparam int numSets = 1 << idxLen;

    // request kinds used in the input file
    localparam int kindIdle = 0;
    localparam int kindHit = 1;
    localparam int kindRegular = 2;
    localparam int kindNoEvict = 3;
    localparam int kindConflict = 4;

    logic      clk;
    logic      rst;
    logic      reqValid[numLanes];
    addr_t     reqAddr[numLanes];
    loadId_t   reqId[numLanes];
    logic      ctRe[numLanes];
    index_t    ctIdx[numLanes];
    logic      ctTagValid[numLanes][numWays];
    tag_t      ctTag[numLanes][numWays];
    way_t      victimWay[numLanes];
    data_t     ctData[numLanes][numWays];
    logic      cacheBusy[numLanes];
    logic      missValid;
    missType_e missType;
    addr_t     missAddr;
    addr_t     missWriteAddr;
    way_t      missWay;
    logic      missReady;
    logic      resValid[numLanes];
    loadId_t   resId[numLanes];
    data_t     resData[numLanes];
    logic      ackFail[numLanes];
    loadId_t   ackId[numLanes];
    addr_t     ackAddr[numLanes];

    // cache-table contents
    logic   tvMem[numSets][numWays];
    tag_t   tagMem[numSets][numWays];
    data_t  dataMem[numSets][numWays];
    way_t   victimMem[numSets];
    // read index held for two edges, lines up with lane stage one
    index_t idx0[numLanes];
    index_t idx1[numLanes];

    // one entry per cycle line of the input file
    int          numCycles;
    logic        loaded = 1'b0;
    logic        lineBusy[maxCycles][numLanes];
    logic        lineReady[maxCycles];
    int          lineKind[maxCycles][numLanes];
    addr_t       lineAddr[maxCycles][numLanes];
    loadId_t     lineId[maxCycles][numLanes];
    logic [31:0] lineExp[maxCycles][numLanes];

    loadUnit dut (.*);

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    always @(posedge clk) begin
        idx0 <= ctIdx;
        idx1 <= idx0;
    end

    for (genvar i = 0; i < numLanes; i++) begin : genModel
        assign victimWay[i] = victimMem[idx1[i]];
        for (genvar w = 0; w < numWays; w++) begin : genWay
            assign ctTagValid[i][w] = tvMem[idx1[i]][w];
            assign ctTag[i][w] = tagMem[idx1[i]][w];
            assign ctData[i][w] = dataMem[idx1[i]][w];
        end
    end

    task automatic stopRun();
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic failWith(input string what);
        $display("Error at %0t ns: %s", $time, what);
        stopRun();
    endtask

    task automatic checkData(input string name, input data_t act, input data_t exp);
        if (act !== exp) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, act, exp);
            stopRun();
        end
    endtask

    task automatic checkAddr(input string name, input addr_t act, input addr_t exp);
        if (act !== exp) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, act, exp);
            stopRun();
        end
    endtask

    task automatic checkMissType(input string name, input missType_e act, input missType_e exp);
        if (act !== exp) begin
            $display("Mismatch at %0t ns: %s is %s, expected %s", $time, name, act.name(),
                exp.name());
            stopRun();
        end
    endtask

    task automatic checkWay(input string name, input way_t act, input way_t exp);
        if (act !== exp) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, act, exp);
            stopRun();
        end
    endtask

    function automatic bit isMiss(input int kind);
        return kind == kindRegular || kind == kindNoEvict;
    endfunction

    // unread ways keep random data, preloaded ways overwrite it
    task automatic fillTable();
        for (int s = 0; s < numSets; s++) begin
            victimMem[s] = '0;
            for (int w = 0; w < numWays; w++) begin
                tvMem[s][w] = 1'b0;
                tagMem[s][w] = '0;
                dataMem[s][w] = $urandom;
            end
        end
    endtask

    task automatic readInput();
        int fd;
        int n;
        string line;
        logic [31:0] f[11];
        fd = $fopen(inputFile, "r");
        if (fd == 0) begin
            failWith({"cannot open ", inputFile});
        end
        numCycles = 0;
        while ($fgets(line, fd) != 0) begin
            if (line.getc(0) == "W") begin
                n = $sscanf(line, "W %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
                if (n != 5) begin
                    failWith({"bad preload line ", line});
                end
                tvMem[index_t'(f[0])][way_t'(f[1])] = f[2][0];
                tagMem[index_t'(f[0])][way_t'(f[1])] = tag_t'(f[3]);
                dataMem[index_t'(f[0])][way_t'(f[1])] = f[4];
            end else if (line.getc(0) == "V") begin
                n = $sscanf(line, "V %h %h", f[0], f[1]);
                if (n != 2) begin
                    failWith({"bad victim line ", line});
                end
                victimMem[index_t'(f[0])] = way_t'(f[1]);
            end else if (line.getc(0) == "C") begin
                n = $sscanf(line, "C %h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                    f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
                if (n != 11 || numCycles >= maxCycles) begin
                    failWith({"bad or surplus cycle line ", line});
                end
                lineReady[numCycles] = f[2][0];
                for (int r = 0; r < numLanes; r++) begin
                    lineBusy[numCycles][r] = f[r][0];
                    lineKind[numCycles][r] = int'(f[3 + 4 * r]);
                    lineAddr[numCycles][r] = f[4 + 4 * r];
                    lineId[numCycles][r] = loadId_t'(f[5 + 4 * r]);
                    lineExp[numCycles][r] = f[6 + 4 * r];
                end
                numCycles++;
            end
        end
        $fclose(fd);
    endtask

    task automatic driveLine(input int k);
        for (int r = 0; r < numLanes; r++) begin
            reqValid[r] = k < numCycles && lineKind[k][r] != kindIdle;
            reqAddr[r] = k < numCycles ? lineAddr[k][r] : '0;
            reqId[r] = k < numCycles ? lineId[k][r] : '0;
            cacheBusy[r] = k < numCycles && lineBusy[k][r];
        end
        // ready belongs to the loads that reach the arbiter this cycle
        missReady = k >= 2 ? lineReady[k - 2] : 1'b1;
    endtask

    // each request reads its own set on some lane, idle requesters read nothing
    task automatic checkIssue(input int k);
        int reads;
        int wanted;
        bit found;
        reads = 0;
        wanted = 0;
        for (int i = 0; i < numLanes; i++) begin
            reads = reads + int'(ctRe[i]);
        end
        for (int r = 0; r < numLanes; r++) begin
            if (lineKind[k][r] != kindIdle) begin
                wanted++;
                found = 1'b0;
                for (int i = 0; i < numLanes; i++) begin
                    if (ctRe[i] && ctIdx[i] == lineAddr[k][r][idxLen-1:0]) begin
                        found = 1'b1;
                    end
                end
                if (!found) begin
                    failWith($sformatf("no cache-table read of set %h for load id %h",
                        lineAddr[k][r][idxLen-1:0], lineId[k][r]));
                end
            end
        end
        if (reads != wanted) begin
            failWith($sformatf("%0d cache-table reads issued, %0d expected", reads, wanted));
        end
    endtask

    task automatic checkLine(input int k);
        int fwd;
        int firstMiss;
        int expOut;
        int actOut;
        int lane;
        bit wantRes;
        bit wantAck;
        fwd = -1;
        firstMiss = -1;
        expOut = 0;
        actOut = 0;
        for (int r = 0; r < numLanes; r++) begin
            if (isMiss(lineKind[k][r])) begin
                if (firstMiss < 0) begin
                    firstMiss = r;
                end
                if (fwd < 0 && lineAddr[k][r] == missAddr) begin
                    fwd = r;
                end
            end
        end
        // the lane is not predicted, the forwarded load is found by its address
        if (firstMiss < 0) begin
            if (missValid) begin
                failWith("missValid is high without a forwardable miss");
            end
        end else begin
            if (!missValid) begin
                failWith("a forwardable miss is missing on the miss output");
            end
            if (fwd < 0) begin
                checkAddr("missAddr", missAddr, lineAddr[k][firstMiss]);
                fwd = firstMiss;
            end
            checkMissType("missType", missType,
                lineKind[k][fwd] == kindRegular ? missRegular : missNoEvict);
            // a miss refills into the victim way of its set
            checkWay("missWay", missWay, victimMem[lineAddr[k][fwd][idxLen-1:0]]);
            if (lineKind[k][fwd] == kindRegular) begin
                checkAddr("missWriteAddr", missWriteAddr, lineExp[k][fwd]);
            end
        end
        for (int r = 0; r < numLanes; r++) begin
            if (lineKind[k][r] != kindIdle) begin
                wantRes = lineKind[k][r] == kindHit;
                wantAck = lineKind[k][r] == kindConflict ||
                    (isMiss(lineKind[k][r]) && (r != fwd || !lineReady[k]));
                expOut = expOut + int'(wantRes) + int'(wantAck);
                lane = -1;
                for (int i = 0; i < numLanes; i++) begin
                    if (resValid[i] && resId[i] == lineId[k][r]) begin
                        lane = i;
                    end
                end
                if (wantRes != (lane >= 0)) begin
                    failWith($sformatf("result for load id %h is %s", lineId[k][r],
                        wantRes ? "missing" : "unexpected"));
                end
                if (wantRes) begin
                    checkData("resData", resData[lane], lineExp[k][r]);
                end
                lane = -1;
                for (int i = 0; i < numLanes; i++) begin
                    if (ackFail[i] && ackId[i] == lineId[k][r]) begin
                        lane = i;
                    end
                end
                if (wantAck != (lane >= 0)) begin
                    failWith($sformatf("failed acknowledge for load id %h is %s",
                        lineId[k][r], wantAck ? "missing" : "unexpected"));
                end
                if (wantAck) begin
                    checkAddr("ackAddr", ackAddr[lane], lineAddr[k][r]);
                end
            end
        end
        for (int i = 0; i < numLanes; i++) begin
            actOut = actOut + int'(resValid[i]) + int'(ackFail[i]);
        end
        if (actOut != expOut) begin
            failWith($sformatf("%0d results and acknowledges seen, %0d expected", actOut,
                expOut));
        end
    endtask

    initial begin
        void'($urandom(randSeed));
        rst = 1'b1;
        missReady = 1'b0;
        for (int r = 0; r < numLanes; r++) begin
            reqValid[r] = 1'b0;
            reqAddr[r] = '0;
            reqId[r] = '0;
            cacheBusy[r] = 1'b0;
        end
        fillTable();
        readInput();
        loaded = 1'b1;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // outcomes of line k show two edges after it is taken
        for (int k = 0; k < numCycles + 2; k++) begin
            driveLine(k);
            #1;
            if (k < numCycles) begin
                checkIssue(k);
            end
            if (k >= 2) begin
                checkLine(k - 2);
            end
            @(negedge clk);
        end
        $display("All tests passed");
        $finish;
    end

    initial begin
        wait (loaded);
        #(numCycles * clkPeriod + timeoutMargin);
        $display("Error at %0t ns: timeout, the run did not finish in time", $time);
        stopRun();
    end

endmodule

`default_nettype wire
